//--- src/riscv_isa_pkg.sv
// RV32I instruction-set constants and encodings, imported by every RTL file of the core
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Instruction field positions
    localparam int OPCODE_LSB     = 0;
    localparam int OPCODE_W       = 7;
    localparam int RD_LSB         = 7;
    localparam int FUNCT3_LSB     = 12;
    localparam int FUNCT3_W       = 3;
    localparam int RS1_LSB        = 15;
    localparam int RS2_LSB        = 20;
    localparam int FUNCT7_ALT_BIT = 30;  // Picks SUB and SRA

    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // Branch compares
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

//--- src/core_ctrl_pkg.sv
// Internal control encodings of the core, shared by the decoder, ALU and writeback stage
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        EQ,   // Branch compares from here on
        NE,
        LT,
        GE,
        LTU,
        GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_RESULT,
        IMMEDIATE,    // LUI
        PC_PLUS_IMM,  // AUIPC
        PC_PLUS_4     // Link address of JAL
    } wb_sel_e;

    typedef enum logic [1:0] {
        SEQUENTIAL,
        BRANCH,
        JUMP
    } pc_sel_e;

endpackage

`default_nettype wire

//--- src/instr_decoder.sv
// Instruction decoder; splits the instruction word into register indices, immediate and controls
`default_nettype none

module instr_decoder (
    input  logic [riscv_isa_pkg::XLEN-1:0]      instr,
    output logic [riscv_isa_pkg::REG_IDX_W-1:0] rs1_idx,
    output logic [riscv_isa_pkg::REG_IDX_W-1:0] rs2_idx,
    output logic [riscv_isa_pkg::REG_IDX_W-1:0] rd_idx,
    output logic [riscv_isa_pkg::XLEN-1:0]      imm,
    output logic                                rs2_use_imm,
    output logic                                rd_we,
    output core_ctrl_pkg::alu_op_e              alu_op,
    output core_ctrl_pkg::wb_sel_e              wb_sel,
    output core_ctrl_pkg::pc_sel_e              pc_sel
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                alt;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_j;

    function automatic alu_op_e arith_op(input logic [FUNCT3_W-1:0] f3, input logic sel_alt);
        case (f3)
            F3_ADD_SUB: arith_op = sel_alt ? SUB : ADD;
            F3_SLL:     arith_op = SLL;
            F3_SLT:     arith_op = SLT;
            F3_SLTU:    arith_op = SLTU;
            F3_XOR:     arith_op = XOR;
            F3_SRL_SRA: arith_op = sel_alt ? SRA : SRL;
            F3_OR:      arith_op = OR;
            default:    arith_op = AND;
        endcase
    endfunction

    function automatic alu_op_e branch_op(input logic [FUNCT3_W-1:0] f3);
        case (f3)
            F3_BEQ:  branch_op = EQ;
            F3_BNE:  branch_op = NE;
            F3_BLT:  branch_op = LT;
            F3_BGE:  branch_op = GE;
            F3_BLTU: branch_op = LTU;
            F3_BGEU: branch_op = GEU;
            default: branch_op = ADD;  // Never taken
        endcase
    endfunction

    assign rs1_idx = instr[RS1_LSB +: REG_IDX_W];
    assign rs2_idx = instr[RS2_LSB +: REG_IDX_W];
    assign rd_idx  = instr[RD_LSB +: REG_IDX_W];
    assign opcode  = opcode_e'(instr[OPCODE_LSB +: OPCODE_W]);
    assign funct3  = instr[FUNCT3_LSB +: FUNCT3_W];
    assign alt     = instr[FUNCT7_ALT_BIT];

    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_b = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm         = '0;
        rs2_use_imm = 1'b0;
        rd_we       = 1'b0;
        alu_op      = ADD;
        wb_sel      = ALU_RESULT;
        pc_sel      = SEQUENTIAL;
        case (opcode)
            OP: begin
                rd_we  = 1'b1;
                alu_op = arith_op(funct3, alt);
            end
            OP_IMM: begin
                rd_we       = 1'b1;
                rs2_use_imm = 1'b1;
                imm         = imm_i;
                alu_op      = arith_op(funct3, alt && (funct3 == F3_SRL_SRA));  // Only SRAI
            end
            LUI: begin
                rd_we  = 1'b1;
                imm    = imm_u;
                wb_sel = IMMEDIATE;
            end
            AUIPC: begin
                rd_we  = 1'b1;
                imm    = imm_u;
                wb_sel = PC_PLUS_IMM;
            end
            riscv_isa_pkg::BRANCH: begin
                imm    = imm_b;
                alu_op = branch_op(funct3);
                pc_sel = core_ctrl_pkg::BRANCH;
            end
            JAL: begin
                rd_we  = 1'b1;
                imm    = imm_j;
                wb_sel = PC_PLUS_4;
                pc_sel = JUMP;
            end
            default: ;  // Unknown opcode retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
// General register file with two combinational read ports and one write port, x0 tied to zero
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                we,
    input  logic [riscv_isa_pkg::REG_IDX_W-1:0] waddr,
    input  logic [riscv_isa_pkg::REG_IDX_W-1:0] raddr1,
    input  logic [riscv_isa_pkg::REG_IDX_W-1:0] raddr2,
    input  logic [riscv_isa_pkg::XLEN-1:0]      wdata,
    output logic [riscv_isa_pkg::XLEN-1:0]      rdata1,
    output logic [riscv_isa_pkg::XLEN-1:0]      rdata2
);
    import riscv_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/alu.sv
// Integer ALU of the core; arithmetic, logic and shift results plus the branch compare
`default_nettype none

module alu (
    input  logic [riscv_isa_pkg::XLEN-1:0] rs1_data,
    input  logic [riscv_isa_pkg::XLEN-1:0] rs2_data,
    input  logic [riscv_isa_pkg::XLEN-1:0] imm,
    input  logic                           rs2_use_imm,
    input  core_ctrl_pkg::alu_op_e         alu_op,
    output logic [riscv_isa_pkg::XLEN-1:0] alu_result,
    output logic                           branch_cond
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic            cmp;

    assign op_a  = rs1_data;
    assign op_b  = rs2_use_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        cmp         = 1'b0;
        branch_cond = 1'b0;
        case (alu_op)
            ADD:  alu_result = op_a + op_b;
            SUB:  alu_result = op_a - op_b;
            SLL:  alu_result = op_a << shamt;
            SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_s};
            SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_u};
            XOR:  alu_result = op_a ^ op_b;
            SRL:  alu_result = op_a >> shamt;
            SRA:  alu_result = $signed(op_a) >>> shamt;
            OR:   alu_result = op_a | op_b;
            AND:  alu_result = op_a & op_b;
            default: begin
                case (alu_op)
                    EQ:      cmp = (op_a == op_b);
                    NE:      cmp = (op_a != op_b);
                    LT:      cmp = lt_s;
                    GE:      cmp = !lt_s;
                    LTU:     cmp = lt_u;
                    default: cmp = !lt_u;  // GEU
                endcase
                branch_cond = cmp;
                alu_result  = {{(XLEN-1){1'b0}}, cmp};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/pc_writeback.sv
// Program counter, next-PC choice, writeback mux and retire record register of the core
`default_nettype none

module pc_writeback (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [riscv_isa_pkg::XLEN-1:0]      imm,
    input  logic [riscv_isa_pkg::XLEN-1:0]      alu_result,
    input  logic                                branch_cond,
    input  logic                                rd_we,
    input  logic [riscv_isa_pkg::REG_IDX_W-1:0] rd_idx,
    input  core_ctrl_pkg::wb_sel_e              wb_sel,
    input  core_ctrl_pkg::pc_sel_e              pc_sel,
    output logic [riscv_isa_pkg::XLEN-1:0]      pc,
    output logic [riscv_isa_pkg::XLEN-1:0]      rd_wdata,
    output logic [riscv_isa_pkg::XLEN-1:0]      retire_pc,
    output logic [riscv_isa_pkg::XLEN-1:0]      retire_data,
    output logic                                retire_valid,
    output logic                                retire_we,
    output logic [riscv_isa_pkg::REG_IDX_W-1:0] retire_rd
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] next_pc;

    assign pc_plus_4   = pc + XLEN'(4);
    assign pc_plus_imm = pc + imm;  // Branch/JAL target and AUIPC value

    always_comb begin
        case (pc_sel)
            JUMP:                  next_pc = pc_plus_imm;
            core_ctrl_pkg::BRANCH: next_pc = branch_cond ? pc_plus_imm : pc_plus_4;
            default:               next_pc = pc_plus_4;
        endcase
    end

    always_comb begin
        case (wb_sel)
            IMMEDIATE:   rd_wdata = imm;
            PC_PLUS_IMM: rd_wdata = pc_plus_imm;
            PC_PLUS_4:   rd_wdata = pc_plus_4;
            default:     rd_wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc           <= RESET_PC;
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            pc           <= next_pc;
            retire_valid <= 1'b1;
            retire_we    <= rd_we;  // Also high for x0
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= pc;
        retire_rd   <= rd_idx;
        retire_data <= rd_we ? rd_wdata : '0;
    end

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
// Top level of the single-cycle RV32I core; instruction comes in on instr, addressed by pc
`default_nettype none

module rv_core_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [riscv_isa_pkg::XLEN-1:0]      instr,
    output logic [riscv_isa_pkg::XLEN-1:0]      pc,
    output logic [riscv_isa_pkg::XLEN-1:0]      retire_pc,
    output logic [riscv_isa_pkg::XLEN-1:0]      retire_data,
    output logic                                retire_valid,
    output logic                                retire_we,
    output logic [riscv_isa_pkg::REG_IDX_W-1:0] retire_rd
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      imm;
    logic                 rs2_use_imm;
    logic                 rd_we;
    alu_op_e              alu_op;
    wb_sel_e              wb_sel;
    pc_sel_e              pc_sel;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      alu_result;
    logic                 branch_cond;
    logic [XLEN-1:0]      rd_wdata;

    instr_decoder u_instr_decoder (
        .instr       (instr),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .imm         (imm),
        .rs2_use_imm (rs2_use_imm),
        .rd_we       (rd_we),
        .alu_op      (alu_op),
        .wb_sel      (wb_sel),
        .pc_sel      (pc_sel)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we),
        .waddr  (rd_idx),
        .raddr1 (rs1_idx),
        .raddr2 (rs2_idx),
        .wdata  (rd_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .rs2_use_imm (rs2_use_imm),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .branch_cond (branch_cond)
    );

    pc_writeback u_pc_writeback (
        .clk          (clk),
        .reset        (reset),
        .imm          (imm),
        .alu_result   (alu_result),
        .branch_cond  (branch_cond),
        .rd_we        (rd_we),
        .rd_idx       (rd_idx),
        .wb_sel       (wb_sel),
        .pc_sel       (pc_sel),
        .pc           (pc),
        .rd_wdata     (rd_wdata),
        .retire_pc    (retire_pc),
        .retire_data  (retire_data),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd)
    );

endmodule

`default_nettype wire

//--- dv/rv_core_tb.sv
// Testbench of the RV32I core; random legal instructions checked against a shadow ISA model
`default_nettype none

module rv_core_tb;
    import riscv_isa_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_INSTR    = 400;
    localparam int          MARGIN       = 20;
    localparam logic [31:0] SEED         = 32'h6f35_7cda;
    localparam logic [31:0] NOP_INSTR    = 32'h0000_0013;  // addi x0, x0, 0

    logic                 clk = 1'b0;
    logic                 reset;
    logic [XLEN-1:0]      instr;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      retire_pc;
    logic [XLEN-1:0]      retire_data;
    logic                 retire_valid;
    logic                 retire_we;
    logic [REG_IDX_W-1:0] retire_rd;

    logic [31:0] lfsr;
    logic [31:0] shadow_regs [NUM_REGS];
    logic [31:0] shadow_pc;

    // Expected retire records, filled at the edge and checked half a cycle later
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] exp_next_q [$];
    logic        exp_we_q [$];
    logic [4:0]  exp_rd_q [$];
    string       exp_name_q [$];

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .pc           (pc),
        .retire_pc    (retire_pc),
        .retire_data  (retire_data),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] build_instr();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic [3:0]  step;
        logic [12:0] boff;
        logic [20:0] joff;
        kind  = take_bits(4);
        rd    = take_bits(3);  // x0..x7 keeps dependencies and x0 frequent
        rs1   = take_bits(3);
        rs2   = take_bits(3);
        f3    = take_bits(3);
        alt   = take_bits(1);
        imm12 = take_bits(12);
        upper = take_bits(20);
        step  = take_bits(4);
        boff  = {{7{step[3]}}, step, 2'b00};   // -32 .. +28
        joff  = {{15{step[3]}}, step, 2'b00};
        if (kind < 4'd7) begin
            if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
        end else if (kind < 4'd11) begin
            if (f3 == 3'd1) imm12[11:5] = 7'b0;
            if (f3 == 3'd5) imm12[11:5] = {1'b0, alt, 5'b0};
            return {imm12, rs1, f3, rd, OP_IMM};
        end else if (kind == 4'd11) begin
            return {upper, rd, LUI};
        end else if (kind == 4'd12) begin
            return {upper, rd, AUIPC};
        end else if (kind < 4'd15) begin
            if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
            return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], BRANCH};
        end else begin
            return {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
        end
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the shadow state and returns its retire record
    function automatic void ref_execute(input logic [31:0] ins, output logic we,
                                        output logic [4:0] rd, output logic [31:0] data,
                                        output string name);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iimm;
        logic [31:0] bimm;
        logic [31:0] jimm;
        logic [31:0] next_pc;
        logic        taken;
        a       = shadow_regs[ins[19:15]];
        b       = shadow_regs[ins[24:20]];
        iimm    = {{20{ins[31]}}, ins[31:20]};
        bimm    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jimm    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        rd      = ins[11:7];
        we      = 1'b1;
        data    = '0;
        taken   = 1'b0;
        next_pc = shadow_pc + 32'd4;
        case (ins[6:0])
            OP: begin
                name = "OP";
                data = alu_ref(ins[14:12], ins[30], a, b);
            end
            OP_IMM: begin
                name = "OP_IMM";
                data = alu_ref(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a, iimm);
            end
            LUI: begin
                name = "LUI";
                data = {ins[31:12], 12'b0};
            end
            AUIPC: begin
                name = "AUIPC";
                data = shadow_pc + {ins[31:12], 12'b0};
            end
            BRANCH: begin
                name = "BRANCH";
                we   = 1'b0;
                case (ins[14:12])
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = !($signed(a) < $signed(b));
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) next_pc = shadow_pc + bimm;
            end
            JAL: begin
                name    = "JAL";
                data    = shadow_pc + 32'd4;
                next_pc = shadow_pc + jimm;
            end
            default: begin
                name = "UNKNOWN";
                we   = 1'b0;
            end
        endcase
        if (we && rd != 5'd0) shadow_regs[rd] = data;
        shadow_pc = next_pc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    initial begin : drive_proc
        logic [31:0] cur;
        logic [31:0] e_data;
        logic        e_we;
        logic [4:0]  e_rd;
        string       e_name;
        lfsr      = SEED;
        shadow_pc = RESET_PC;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow_regs[i] = '0;
        end
        reset = 1'b1;
        instr = NOP_INSTR;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        cur = build_instr();
        instr <= cur;
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);  // cur retires at this edge
            exp_pc_q.push_back(shadow_pc);
            ref_execute(cur, e_we, e_rd, e_data, e_name);
            exp_we_q.push_back(e_we);
            exp_rd_q.push_back(e_rd);
            exp_data_q.push_back(e_data);
            exp_name_q.push_back(e_name);
            exp_next_q.push_back(shadow_pc);
            cur = build_instr();
            instr <= cur;
        end
    end

    initial begin : compare_proc
        string tag;
        logic  e_we;
        @(negedge clk);
        while (reset) begin
            check_value("reset pc", RESET_PC, pc);
            check_value("reset retire_valid", 32'd0, retire_valid);
            check_value("reset retire_we", 32'd0, retire_we);
            @(negedge clk);
        end
        check_value("first edge pc", RESET_PC, pc);
        check_value("first edge retire_valid", 32'd0, retire_valid);
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(negedge clk);
            if (exp_pc_q.size() == 0) begin
                $display("No expected retire record for instruction %0d", n);
                $display("ERRORS FOUND");
                $fatal(1);
            end
            tag  = $sformatf("%s #%0d", exp_name_q.pop_front(), n);
            e_we = exp_we_q.pop_front();
            check_value({tag, " retire_valid"}, 32'd1, retire_valid);
            check_value({tag, " retire_pc"}, exp_pc_q.pop_front(), retire_pc);
            check_value({tag, " retire_we"}, e_we, retire_we);
            if (e_we) check_value({tag, " retire_rd"}, exp_rd_q.pop_front(), retire_rd);
            else void'(exp_rd_q.pop_front());
            check_value({tag, " retire_data"}, exp_data_q.pop_front(), retire_data);
            check_value({tag, " next pc"}, exp_next_q.pop_front(), pc);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + NUM_INSTR + MARGIN) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected time");
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- flist.f
src/riscv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_writeback.sv
src/rv_core_top.sv
dv/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - src/riscv_isa_pkg.sv
  - src/core_ctrl_pkg.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/pc_writeback.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - dv/rv_core_tb.sv
